/* logic/mem_pkg.sv */
`default_nettype none

package mem_pkg;

   typedef logic [15:0] mem_word_t;   // one data word
   typedef logic [15:0] mem_addr_t;   // word address, 64K words

   typedef enum logic {
      MEM_RD = 1'b0,
      MEM_WR = 1'b1
   } mem_op_e;

   // request from a cache, or the one forwarded to memory
   typedef struct packed {
      mem_op_e   op;
      mem_addr_t addr;
      mem_word_t wdata;
   } mem_req_t;

   typedef struct packed {
      logic      valid;   // completion, one cycle
      mem_word_t rdata;   // only meaningful for reads
   } mem_rsp_t;

endpackage

`default_nettype wire

/* logic/cache_pkg.sv */
`default_nettype none

package cache_pkg;

   // widest tag, for a cache of two lines
   localparam int CACHE_TAG_MAX = 15;

   typedef enum logic [1:0] {
      C_IDLE,
      C_FILL,    // read miss, waiting on memory
      C_WRITE    // store going through to memory
   } cache_state_e;

   typedef enum logic [1:0] {
      OWN_NONE,
      OWN_I,
      OWN_D
   } arb_owner_e;

   // narrower tags are kept zero extended
   typedef struct packed {
      logic                     valid;
      logic [CACHE_TAG_MAX-1:0] tag;
      mem_pkg::mem_word_t       data;
   } cache_line_t;

endpackage

`default_nettype wire

/* logic/icache.sv */
`timescale 1ns/1ns
`default_nettype none

module icache #(
   parameter int INDEX_BITS = 4
) (
   input  wire logic               clk,
   input  wire logic               i_rst_n,
   input  wire mem_pkg::mem_addr_t i_pc,
   input  wire mem_pkg::mem_rsp_t  i_rsp,
   output mem_pkg::mem_word_t      o_instr,
   output logic                    o_busy,
   output logic                    o_req,
   output mem_pkg::mem_req_t       o_pkt
);
   import mem_pkg::*;
   import cache_pkg::*;

   localparam int LINES    = 2 ** INDEX_BITS;
   localparam int TAG_BITS = 16 - INDEX_BITS;

   cache_state_e             state_q;
   cache_state_e             state_d;
   cache_line_t              lines [LINES];
   cache_line_t              line;
   logic [INDEX_BITS-1:0]    idx;
   logic [CACHE_TAG_MAX-1:0] tag;
   logic                     hit;

   assign idx  = i_pc[INDEX_BITS-1:0];
   assign tag  = CACHE_TAG_MAX'(i_pc[15 -: TAG_BITS]);
   assign line = lines[idx];
   assign hit  = line.valid && (line.tag == tag);

   assign o_instr = line.data;
   assign o_busy  = (state_q != C_IDLE) || !hit;   // miss shows busy right away
   assign o_req   = (state_q == C_FILL);
   assign o_pkt   = '{op: MEM_RD, addr: i_pc, wdata: '0};

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         C_IDLE:  if (!hit) state_d = C_FILL;
         C_FILL:  if (i_rsp.valid) state_d = C_IDLE;
         default: state_d = C_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_q <= C_IDLE;
         for (int i = 0; i < LINES; i++) begin
            lines[i].valid <= 1'b0;
         end
      end else begin
         state_q <= state_d;
         if (state_q == C_FILL && i_rsp.valid) begin
            lines[idx] <= '{valid: 1'b1, tag: tag, data: i_rsp.rdata};  // fill on completion
         end
      end
   end

   // pc stays on the missed address until the fill completes
   a_req_held: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_req && !i_rsp.valid |=> $stable(o_pkt.addr));

endmodule

`default_nettype wire

/* logic/dcache.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache #(
   parameter int INDEX_BITS = 4
) (
   input  wire logic               clk,
   input  wire logic               i_rst_n,
   input  wire logic               i_en,
   input  wire logic               i_wr,
   input  wire mem_pkg::mem_addr_t i_addr,
   input  wire mem_pkg::mem_word_t i_wdata,
   input  wire mem_pkg::mem_rsp_t  i_rsp,
   output mem_pkg::mem_word_t      o_rdata,
   output logic                    o_busy,
   output logic                    o_req,
   output mem_pkg::mem_req_t       o_pkt
);
   import mem_pkg::*;
   import cache_pkg::*;

   localparam int LINES    = 2 ** INDEX_BITS;
   localparam int TAG_BITS = 16 - INDEX_BITS;

   cache_state_e             state_q;
   cache_state_e             state_d;
   cache_line_t              lines [LINES];
   cache_line_t              line;
   logic [INDEX_BITS-1:0]    idx;
   logic [CACHE_TAG_MAX-1:0] tag;
   logic                     hit;
   logic                     wr_done_q;   // store finished last cycle
   logic                     accept_wr;
   logic                     rd_miss;

   assign idx  = i_addr[INDEX_BITS-1:0];
   assign tag  = CACHE_TAG_MAX'(i_addr[15 -: TAG_BITS]);
   assign line = lines[idx];
   assign hit  = line.valid && (line.tag == tag);

   // a held store must not start again once it has completed
   assign accept_wr = (state_q == C_IDLE) && i_en && i_wr && !wr_done_q;
   assign rd_miss   = i_en && !i_wr && !hit;

   assign o_rdata = line.data;
   assign o_busy  = (state_q != C_IDLE) || accept_wr || rd_miss;
   assign o_req   = (state_q != C_IDLE);

   always_comb begin
      o_pkt.op    = (state_q == C_WRITE) ? MEM_WR : MEM_RD;
      o_pkt.addr  = i_addr;    // held by the processor while busy
      o_pkt.wdata = i_wdata;
   end

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         C_IDLE: begin
            if (accept_wr) state_d = C_WRITE;   // write-through, every store
            else if (rd_miss) state_d = C_FILL;
         end
         C_FILL,
         C_WRITE: if (i_rsp.valid) state_d = C_IDLE;
         default: state_d = C_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_q   <= C_IDLE;
         wr_done_q <= 1'b0;
         for (int i = 0; i < LINES; i++) begin
            lines[i].valid <= 1'b0;
         end
      end else begin
         state_q   <= state_d;
         wr_done_q <= (state_q == C_WRITE) && i_rsp.valid;
         if (accept_wr && hit) begin
            lines[idx].data <= i_wdata;   // no allocate on a store miss
         end
         if (state_q == C_FILL && i_rsp.valid) begin
            lines[idx] <= '{valid: 1'b1, tag: tag, data: i_rsp.rdata};
         end
      end
   end

   // processor keeps the access steady until busy drops
   a_inputs_held: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_busy |=> $stable({i_en, i_wr, i_addr, i_wdata}));

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
   input  wire logic              clk,
   input  wire logic              i_rst_n,
   input  wire logic              i_i_req,
   input  wire mem_pkg::mem_req_t i_i_pkt,
   input  wire logic              i_d_req,
   input  wire mem_pkg::mem_req_t i_d_pkt,
   input  wire mem_pkg::mem_rsp_t i_mem_rsp,
   output logic                   o_mem_start,
   output mem_pkg::mem_req_t      o_mem_pkt,
   output mem_pkg::mem_rsp_t      o_i_rsp,
   output mem_pkg::mem_rsp_t      o_d_rsp
);
   import mem_pkg::*;
   import cache_pkg::*;

   arb_owner_e owner_q;
   arb_owner_e owner_d;
   arb_owner_e pick;
   logic       any_req;

   assign any_req = i_i_req || i_d_req;
   assign pick    = i_i_req ? OWN_I : OWN_D;   // instruction side first

   assign o_mem_start = (owner_q == OWN_NONE) && any_req;   // one shot per grant
   assign o_mem_pkt   = (pick == OWN_I) ? i_i_pkt : i_d_pkt;

   // completion only goes back to the owner
   assign o_i_rsp = '{valid: i_mem_rsp.valid && (owner_q == OWN_I), rdata: i_mem_rsp.rdata};
   assign o_d_rsp = '{valid: i_mem_rsp.valid && (owner_q == OWN_D), rdata: i_mem_rsp.rdata};

   always_comb begin
      owner_d = owner_q;
      if (owner_q == OWN_NONE) begin
         if (any_req) owner_d = pick;
      end else if (i_mem_rsp.valid) begin
         owner_d = OWN_NONE;   // free again next cycle
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) owner_q <= OWN_NONE;
      else owner_q <= owner_d;
   end

   // the owning cache keeps its request up through its completion
   a_owner_req_held: assert property (@(posedge clk) disable iff (!i_rst_n)
      (owner_q != OWN_NONE) |-> ((owner_q == OWN_I) ? i_i_req : i_d_req));

   // memory never completes without an owner waiting on it
   a_rsp_owned: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_mem_rsp.valid |-> (owner_q != OWN_NONE));

endmodule

`default_nettype wire

/* logic/main_memory.sv */
`timescale 1ns/1ns
`default_nettype none

module main_memory #(
   parameter int MEM_LATENCY = 4
) (
   input  wire logic              clk,
   input  wire logic              i_rst_n,
   input  wire logic              i_start,
   input  wire mem_pkg::mem_req_t i_pkt,
   output mem_pkg::mem_rsp_t      o_rsp
);
   import mem_pkg::*;

   typedef struct packed {
      logic      valid;
      mem_op_e   op;
      mem_addr_t addr;
   } stage_t;

   mem_word_t mem_array [65536];
   stage_t    pipe_q [MEM_LATENCY];
   stage_t    tail;

   // stores land at the strobe
   always_ff @(posedge clk) begin
      if (i_start && i_pkt.op == MEM_WR) begin
         mem_array[i_pkt.addr] <= i_pkt.wdata;
      end
   end

   // fixed delay line, a new strobe can enter every cycle
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         for (int i = 0; i < MEM_LATENCY; i++) begin
            pipe_q[i].valid <= 1'b0;
         end
      end else begin
         pipe_q[0] <= '{valid: i_start, op: i_pkt.op, addr: i_pkt.addr};
         for (int i = 1; i < MEM_LATENCY; i++) begin
            pipe_q[i] <= pipe_q[i-1];
         end
      end
   end

   assign tail = pipe_q[MEM_LATENCY-1];

   assign o_rsp.valid = tail.valid;   // writes complete too
   assign o_rsp.rdata = (tail.op == MEM_RD) ? mem_array[tail.addr] : '0;

endmodule

`default_nettype wire

/* logic/memory_system.sv */
`timescale 1ns/1ns
`default_nettype none

module memory_system #(
   parameter int INDEX_BITS  = 4,
   parameter int MEM_LATENCY = 4
) (
   input  wire logic               clk,
   input  wire logic               i_rst_n,
   input  wire mem_pkg::mem_addr_t i_pc,
   output mem_pkg::mem_word_t      o_instr,
   output logic                    o_i_busy,
   input  wire logic               i_d_en,
   input  wire logic               i_d_wr,
   input  wire mem_pkg::mem_addr_t i_d_addr,
   input  wire mem_pkg::mem_word_t i_d_wdata,
   output mem_pkg::mem_word_t      o_d_rdata,
   output logic                    o_d_busy
);
   import mem_pkg::*;

   // cache side of the arbiter
   logic     i_req;
   logic     d_req;
   mem_req_t i_pkt;
   mem_req_t d_pkt;
   mem_rsp_t i_rsp;
   mem_rsp_t d_rsp;

   // memory side
   logic     mem_start;
   mem_req_t mem_pkt;
   mem_rsp_t mem_rsp;

   icache #(.INDEX_BITS(INDEX_BITS)) u_icache (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_pc    (i_pc),
      .i_rsp   (i_rsp),
      .o_instr (o_instr),
      .o_busy  (o_i_busy),
      .o_req   (i_req),
      .o_pkt   (i_pkt)
   );

   dcache #(.INDEX_BITS(INDEX_BITS)) u_dcache (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_en    (i_d_en),
      .i_wr    (i_d_wr),
      .i_addr  (i_d_addr),
      .i_wdata (i_d_wdata),
      .i_rsp   (d_rsp),
      .o_rdata (o_d_rdata),
      .o_busy  (o_d_busy),
      .o_req   (d_req),
      .o_pkt   (d_pkt)
   );

   mem_arbiter u_arbiter (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_i_req     (i_req),
      .i_i_pkt     (i_pkt),
      .i_d_req     (d_req),
      .i_d_pkt     (d_pkt),
      .i_mem_rsp   (mem_rsp),
      .o_mem_start (mem_start),
      .o_mem_pkt   (mem_pkt),
      .o_i_rsp     (i_rsp),
      .o_d_rsp     (d_rsp)
   );

   main_memory #(.MEM_LATENCY(MEM_LATENCY)) u_mem (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_start (mem_start),
      .i_pkt   (mem_pkt),
      .o_rsp   (mem_rsp)
   );

endmodule

`default_nettype wire

/* verif/memory_system_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module memory_system_tb;
   import mem_pkg::*;

   localparam int INDEX_BITS   = 4;
   localparam int MEM_LATENCY  = 4;
   localparam int CLK_PERIOD   = 40;
   localparam int N_RAND       = 16;
   localparam int N_SHARED     = 8;
   // one miss, plus a whole transaction of the other side ahead of it
   localparam int ACCESS_LIMIT = 2 * (MEM_LATENCY + 3) + 4;
   localparam int CONTENTION   = 2;
   localparam int N_ACCESSES   = 3 + 3 * N_RAND + 3 * N_SHARED + 4 + 8 + 4;
   localparam int WATCHDOG_NS  = N_ACCESSES * ACCESS_LIMIT * CONTENTION * CLK_PERIOD;

   logic      clk;
   logic      rst_n;
   mem_addr_t pc;
   mem_word_t instr;
   logic      i_busy;
   logic      d_en;
   logic      d_wr;
   mem_addr_t d_addr;
   mem_word_t d_wdata;
   mem_word_t d_rdata;
   logic      d_busy;

   mem_word_t   ref_mem [mem_addr_t];   // every store the testbench issued
   logic [31:0] rng_state = 32'hf8d0cd4d;

   memory_system #(
      .INDEX_BITS  (INDEX_BITS),
      .MEM_LATENCY (MEM_LATENCY)
   ) uut (
      .clk       (clk),
      .i_rst_n   (rst_n),
      .i_pc      (pc),
      .o_instr   (instr),
      .o_i_busy  (i_busy),
      .i_d_en    (d_en),
      .i_d_wr    (d_wr),
      .i_d_addr  (d_addr),
      .i_d_wdata (d_wdata),
      .o_d_rdata (d_rdata),
      .o_d_busy  (d_busy)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   task automatic abort_run();
      $display("sim failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_word(input string name, input mem_word_t got, input mem_word_t want);
      if (got !== want) begin
         $display("error: %s = 0x%h, expected 0x%h", name, got, want);
         abort_run();
      end
   endtask

   task automatic check_busy(input string name, input logic got, input logic want);
      if (got !== want) begin
         $display("error: %s = 0x%h, expected 0x%h", name, got, want);
         abort_run();
      end
   endtask

   task automatic lookup_model(input mem_addr_t addr, output mem_word_t word);
      if (!ref_mem.exists(addr)) begin
         $display("address 0x%h was never stored, nothing to compare with", addr);
         abort_run();
      end
      word = ref_mem[addr];
   endtask

   // called at a falling edge, returns at the falling edge where busy is low
   task automatic wait_not_busy(input bit data_side, input string what, output int cycles);
      cycles = 0;
      while ((data_side ? d_busy : i_busy) !== 1'b0) begin
         if (cycles >= ACCESS_LIMIT) begin
            $display("%s still busy after %0d cycles", what, ACCESS_LIMIT);
            abort_run();
         end
         @(negedge clk);
         cycles++;
      end
   endtask

   task automatic d_write(input mem_addr_t addr, input mem_word_t data);
      int cycles;
      @(posedge clk);
      d_en    <= 1'b1;
      d_wr    <= 1'b1;
      d_addr  <= addr;
      d_wdata <= data;
      @(negedge clk);
      check_busy("o_d_busy", d_busy, 1'b1);   // write-through, always to memory
      wait_not_busy(1'b1, "data store", cycles);
      ref_mem[addr] = data;
      @(posedge clk);
      d_en <= 1'b0;   // else the held store would go out again
   endtask

   task automatic d_read(input mem_addr_t addr, input bit expect_hit);
      int        cycles;
      mem_word_t want;
      @(posedge clk);
      d_en   <= 1'b1;
      d_wr   <= 1'b0;
      d_addr <= addr;
      @(negedge clk);
      check_busy("o_d_busy", d_busy, !expect_hit);
      wait_not_busy(1'b1, "data read", cycles);
      lookup_model(addr, want);
      check_word($sformatf("o_d_rdata[0x%h]", addr), d_rdata, want);
      @(posedge clk);
      d_en <= 1'b0;
   endtask

   // pc stays put afterwards, it hits so the icache stays quiet
   task automatic i_fetch(input mem_addr_t addr, input bit expect_hit);
      int        cycles;
      mem_word_t want;
      @(posedge clk);
      pc <= addr;
      @(negedge clk);
      check_busy("o_i_busy", i_busy, !expect_hit);
      wait_not_busy(1'b0, "instruction fetch", cycles);
      lookup_model(addr, want);
      check_word($sformatf("o_instr[0x%h]", addr), instr, want);
   endtask

   task automatic reset_state();
      int cycles;
      @(negedge clk);
      check_busy("o_d_busy", d_busy, 1'b0);
      // icache fetches whatever pc points at right out of reset
      wait_not_busy(1'b0, "fetch after reset", cycles);
      d_write(16'h0040, 16'h5a3c);
      d_read(16'h0040, 1'b0);   // lines all invalid
   endtask

   task automatic write_through_reads();
      mem_addr_t   addrs [$];
      mem_addr_t   addr;
      logic [31:0] r;
      for (int i = 0; i < N_RAND; i++) begin
         do begin
            r    = next_rand();
            addr = {4'h1, r[11:0]};
         end while (ref_mem.exists(addr));
         addrs.push_back(addr);
         d_write(addr, r[31:16]);
      end
      foreach (addrs[i]) begin
         d_read(addrs[i], 1'b0);   // stores do not allocate
         d_read(addrs[i], 1'b1);
      end
   endtask

   task automatic shared_fetches();
      logic [31:0] r;
      for (int i = 0; i < N_SHARED; i++) begin
         r = next_rand();
         d_write(16'h2000 + mem_addr_t'(3 * i), r[15:0]);
      end
      for (int i = 0; i < N_SHARED; i++) begin
         i_fetch(16'h2000 + mem_addr_t'(3 * i), 1'b0);
         i_fetch(16'h2000 + mem_addr_t'(3 * i), 1'b1);
      end
   endtask

   task automatic priority_contention();
      mem_addr_t   i_addr;
      mem_addr_t   rd_addr;
      mem_word_t   want;
      logic [31:0] r;
      int          cycles_i;
      int          cycles_d;
      i_addr  = 16'h3004;
      rd_addr = 16'h3109;
      r = next_rand();
      d_write(i_addr, r[15:0]);
      d_write(rd_addr, ~r[15:0]);   // the two words always differ
      @(posedge clk);
      pc     <= i_addr;   // both sides miss in the same cycle
      d_en   <= 1'b1;
      d_wr   <= 1'b0;
      d_addr <= rd_addr;
      @(negedge clk);
      check_busy("o_i_busy", i_busy, 1'b1);
      check_busy("o_d_busy", d_busy, 1'b1);
      fork
         wait_not_busy(1'b0, "contended fetch", cycles_i);
         wait_not_busy(1'b1, "contended data read", cycles_d);
      join
      lookup_model(i_addr, want);
      check_word($sformatf("o_instr[0x%h]", i_addr), instr, want);
      lookup_model(rd_addr, want);
      check_word($sformatf("o_d_rdata[0x%h]", rd_addr), d_rdata, want);
      if (cycles_i >= cycles_d) begin
         $display("instruction side took %0d cycles and data side %0d, instruction side must win",
                  cycles_i, cycles_d);
         abort_run();
      end
      @(posedge clk);
      d_en <= 1'b0;
   endtask

   task automatic conflict_eviction();
      logic [31:0] r;
      r = next_rand();
      d_write(16'h4005, r[15:0]);   // same index, different tags
      d_write(16'h5005, ~r[15:0]);
      d_read(16'h4005, 1'b0);
      d_read(16'h5005, 1'b0);
      d_read(16'h4005, 1'b0);
      i_fetch(16'h4005, 1'b0);
      i_fetch(16'h5005, 1'b0);
      i_fetch(16'h4005, 1'b0);
   endtask

   task automatic write_hit_update();
      logic [31:0] r;
      mem_word_t   old;
      r = next_rand();
      lookup_model(16'h4005, old);
      d_write(16'h4005, ~old);   // still cached from the eviction test
      d_read(16'h4005, 1'b1);
      d_write(16'h6007, r[31:16]);
      d_read(16'h6007, 1'b0);
   endtask

   initial begin
      rst_n   = 1'b0;
      pc      = '0;
      d_en    = 1'b0;
      d_wr    = 1'b0;
      d_addr  = '0;
      d_wdata = '0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      reset_state();
      write_through_reads();
      shared_fetches();
      priority_contention();
      conflict_eviction();
      write_hit_update();
      $display("sim passed");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("run did not finish within %0d ns, a cache is stuck", WATCHDOG_NS);
      abort_run();
   end

endmodule

`default_nettype wire

/* sim.f */
logic/mem_pkg.sv
logic/cache_pkg.sv
logic/icache.sv
logic/dcache.sv
logic/mem_arbiter.sv
logic/main_memory.sv
logic/memory_system.sv
verif/memory_system_tb.sv

/* Makefile */
VERILATOR := verilator
TOP       := memory_system_tb
RTL_TOP   := memory_system
FILELIST  := sim.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0
LINTFLAGS := --lint-only -Wall --timing --timescale 1ns/1ns

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
